//--- bench/g2_point_op_model.sv
// Behavioral stand-in for the external G2 point-arithmetic unit, no curve math.
// DBL doubles all six words of R; ADD adds Q into x and y and keeps z.
// Arithmetic wraps at 2^FE_BITS. Answers 1 to 8 cycles after each request.
// Outputs change on falling edges; o_overlap is sticky until reset.
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module g2_point_op_model
  import g2_smul_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_op_strobe,
  input  point_req_t i_op_req,
  output logic       o_res_strobe,
  output g2_jb_t     o_res_point,
  output logic       o_overlap    // Request seen while one was still pending
);

  logic   pending;
  int     delay;
  g2_jb_t held;

  function automatic g2_jb_t apply_op(input point_req_t req);
    g2_jb_t p;
    p = req.r;
    if (req.op == OP_DBL) begin
      p.x.c0 = req.r.x.c0 << 1;
      p.x.c1 = req.r.x.c1 << 1;
      p.y.c0 = req.r.y.c0 << 1;
      p.y.c1 = req.r.y.c1 << 1;
      p.z.c0 = req.r.z.c0 << 1;
      p.z.c1 = req.r.z.c1 << 1;
    end else begin
      p.x.c0 = req.r.x.c0 + req.q.x.c0;
      p.x.c1 = req.r.x.c1 + req.q.x.c1;
      p.y.c0 = req.r.y.c0 + req.q.y.c0;
      p.y.c1 = req.r.y.c1 + req.q.y.c1;
    end
    return p;
  endfunction

  initial begin
    o_res_strobe = 1'b0;
    o_res_point  = '0;
    o_overlap    = 1'b0;
    pending      = 1'b0;
    delay        = 0;
  end

  always @(negedge i_clk) begin
    o_res_strobe <= 1'b0;
    if (i_rst) begin
      pending   <= 1'b0;
      delay     <= 0;
      o_overlap <= 1'b0;
    end else begin
      if (pending) begin
        if (delay <= 1) begin
          o_res_strobe <= 1'b1;
          o_res_point  <= held;
          pending      <= 1'b0;
        end else begin
          delay <= delay - 1;
        end
      end
      if (i_op_strobe) begin
        if (pending) begin
          o_overlap <= 1'b1;
        end
        held    <= apply_op(i_op_req);
        delay   <= 1 + int'($urandom % 8);  // Random latency 1..8
        pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_g2_smul.sv
// Table-driven testbench for g2_smul_top with a behavioral point-op unit.
// Expected words apply the model rules (DBL doubles each word, ADD adds Q to x and y).
// Inputs change on falling edges and outputs are sampled on falling edges.
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module tb_g2_smul
  import g2_smul_pkg::*;
();

  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (`KEY_BITS * 2 * 9 + 40);

  typedef struct packed {
    key_t       key;
    logic       poke;   // Three stray input words while busy
    g2_af_t     q;
    g2_jb_t     exp;
    logic [7:0] n_dbl;
    logic [7:0] n_add;
  } row_t;

  logic       clk;
  logic       rst;
  logic       in_strobe;
  fe_t        in_word;
  key_t       in_key;
  logic       busy;
  logic       op_strobe;
  point_req_t op_req;
  logic       res_strobe;
  g2_jb_t     res_point;
  logic       op_overlap;
  logic       out_strobe;
  fe_t        out_word;
  logic       out_first;
  logic       out_last;

  row_t rows [NUM_ROWS];
  int   cycle_cnt;
  int   dbl_seen;
  int   add_seen;
  int   row_errs;
  int   err_total;
  int   n_fail;

  g2_smul_top g2_smul_top_inst (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_in_strobe  (in_strobe),
    .i_in_word    (in_word),
    .i_key        (in_key),
    .o_busy       (busy),
    .o_op_strobe  (op_strobe),
    .o_op_req     (op_req),
    .i_res_strobe (res_strobe),
    .i_res_point  (res_point),
    .o_out_strobe (out_strobe),
    .o_out_word   (out_word),
    .o_out_first  (out_first),
    .o_out_last   (out_last)
  );

  g2_point_op_model g2_point_op_model_inst (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_op_strobe  (op_strobe),
    .i_op_req     (op_req),
    .o_res_strobe (res_strobe),
    .o_res_point  (res_point),
    .o_overlap    (op_overlap)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the job never finished", cycle_cnt);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Count point-op requests per job
  always @(negedge clk) begin
    if (!rst && op_strobe) begin
      if (op_req.op == OP_DBL) begin
        dbl_seen = dbl_seen + 1;
      end else begin
        add_seen = add_seen + 1;
      end
    end
  end

  function automatic fe_t rand_fe();
    fe_t v;
    int  i;
    v = '0;
    for (i = 0; i < (`FE_BITS + 31) / 32; i++) begin
      v = (v << 32) | fe_t'($urandom);
    end
    return v;
  endfunction

  function automatic fe_t jb_word(input g2_jb_t p, input int k);
    case (k)
      0: return p.x.c0;
      1: return p.x.c1;
      2: return p.y.c0;
      3: return p.y.c1;
      4: return p.z.c0;
      default: return p.z.c1;
    endcase
  endfunction

  // Random Q and a double-and-add over the key with the model's word rules
  function automatic row_t make_row(input key_t key, input logic poke);
    row_t r;
    fe_t  w [6];
    fe_t  qw [4];
    logic started;
    int   i;
    int   b;
    r       = '0;
    r.key   = key;
    r.poke  = poke;
    started = 1'b0;
    for (i = 0; i < 4; i++) begin
      qw[i] = rand_fe();
    end
    for (i = 0; i < 6; i++) begin
      w[i] = '0;
    end
    for (b = `KEY_BITS - 1; b >= 0; b--) begin
      if (started) begin
        for (i = 0; i < 6; i++) begin
          w[i] = w[i] << 1;  // Wraps at FE_BITS
        end
        r.n_dbl = r.n_dbl + 1'b1;
        if (key[b]) begin
          for (i = 0; i < 4; i++) begin
            w[i] = w[i] + qw[i];
          end
          r.n_add = r.n_add + 1'b1;
        end
      end else if (key[b]) begin
        started = 1'b1;  // Leading one loads R = (Qx, Qy, 1)
        for (i = 0; i < 4; i++) begin
          w[i] = qw[i];
        end
        w[4] = fe_t'(1);
      end
    end
    r.q.x.c0   = qw[0];
    r.q.x.c1   = qw[1];
    r.q.y.c0   = qw[2];
    r.q.y.c1   = qw[3];
    r.exp.x.c0 = w[0];
    r.exp.x.c1 = w[1];
    r.exp.y.c0 = w[2];
    r.exp.y.c1 = w[3];
    r.exp.z.c0 = w[4];
    r.exp.z.c1 = w[5];
    return r;
  endfunction

  task automatic flag_mismatch(input string name, input fe_t exp, input fe_t got);
    $display("[FAIL] %s expected %h got %h", name, exp, got);
    row_errs = row_errs + 1;
  endtask

  task automatic flag_problem(input string what);
    $display("%s", what);
    row_errs = row_errs + 1;
  endtask

  task automatic finish_test(input string name);
    $display("%s: %s", name, (row_errs == 0) ? "ok" : "errors");
    err_total = err_total + row_errs;
    if (row_errs != 0) begin
      n_fail = n_fail + 1;
    end
  endtask

  // Starts and ends on a falling edge and leaves a random gap after the strobe
  task automatic send_word(input fe_t word, input key_t key);
    in_strobe = 1'b1;
    in_word   = word;
    in_key    = key;
    @(negedge clk);
    in_strobe = 1'b0;
    repeat ($urandom % 3) @(negedge clk);
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   k;
    r        = rows[idx];
    row_errs = 0;
    dbl_seen = 0;
    add_seen = 0;
    send_word(r.q.x.c0, r.key);
    send_word(r.q.x.c1, ~r.key);  // Key is only taken with word one
    send_word(r.q.y.c0, ~r.key);
    send_word(r.q.y.c1, ~r.key);
    if (r.poke) begin
      if (!busy) begin
        flag_problem("o_busy did not rise after the fourth input word");
      end
      // A partial frame would misalign the next job if it were taken
      send_word(~r.q.x.c0, ~r.key);
      send_word(~r.q.x.c1, ~r.key);
      send_word(~r.q.y.c0, ~r.key);
    end
    while (!out_strobe) begin
      @(negedge clk);
    end
    for (k = 0; k < `OUT_WORDS; k++) begin
      if (!out_strobe) begin
        flag_problem($sformatf("Output strobe dropped before word %0d", k));
      end
      if (out_first !== (k == 0)) begin
        flag_mismatch("o_out_first", fe_t'(k == 0), fe_t'(out_first));
      end
      if (out_last !== (k == `OUT_WORDS - 1)) begin
        flag_mismatch("o_out_last", fe_t'(k == `OUT_WORDS - 1), fe_t'(out_last));
      end
      if (out_word !== jb_word(r.exp, k)) begin
        flag_mismatch($sformatf("o_out_word[%0d]", k), jb_word(r.exp, k), out_word);
      end
      @(negedge clk);
    end
    if (out_strobe) begin
      flag_problem("More than six output words in one frame");
    end
    if (busy) begin
      flag_problem("o_busy still high after the last output word");
    end
    if (dbl_seen != r.n_dbl) begin
      flag_mismatch("op_dbl_count", fe_t'(r.n_dbl), fe_t'(dbl_seen));
    end
    if (add_seen != r.n_add) begin
      flag_mismatch("op_add_count", fe_t'(r.n_add), fe_t'(add_seen));
    end
    if (op_overlap) begin
      flag_problem("A point-op request went out while another was pending");
    end
    finish_test($sformatf("test %0d key %h", idx, r.key));
  endtask

  initial begin
    void'($urandom(32'h86464064));
    cycle_cnt = 0;
    dbl_seen  = 0;
    add_seen  = 0;
    err_total = 0;
    n_fail    = 0;
    rst       = 1'b1;
    in_strobe = 1'b0;
    in_word   = '0;
    in_key    = '0;

    rows[0] = make_row(key_t'(1), 1'b0);
    rows[1] = make_row(key_t'(5), 1'b0);
    rows[2] = make_row('1, 1'b0);
    rows[3] = make_row('0, 1'b0);
    rows[4] = make_row(key_t'({$urandom, $urandom}), 1'b1);
    rows[5] = make_row(key_t'({$urandom, $urandom}), 1'b0);
    rows[6] = make_row(key_t'($urandom % 256), 1'b1);
    rows[7] = make_row(key_t'(1) << (`KEY_BITS - 1), 1'b0);

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst      = 1'b0;
    row_errs = 0;
    repeat (4) begin
      @(negedge clk);
      if (busy || op_strobe || out_strobe) begin
        flag_problem("Outputs not idle after reset");
      end
    end
    finish_test("idle after reset");

    for (int idx = 0; idx < NUM_ROWS; idx++) begin
      run_row(idx);
    end

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             NUM_ROWS + 1, NUM_ROWS + 1 - n_fail, n_fail, err_total);
    if (n_fail == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/g2_smul_pkg.sv
design/g2_input_loader.sv
design/g2_smul_sequencer.sv
design/g2_result_serializer.sv
design/g2_smul_top.sv
bench/g2_point_op_model.sv
bench/tb_g2_smul.sv

//--- design/g2_input_loader.sv
// Collects the four affine Q words into one job and samples the key on word one.
// Words may be spread out in time but must come in order x.c0, x.c1, y.c0, y.c1.
// Input strobes are dropped while busy; busy holds until i_done_strobe.
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module g2_input_loader
  import g2_smul_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_in_strobe,
  input  fe_t    i_in_word,
  input  key_t   i_key,
  input  logic   i_done_strobe,
  output logic   o_load_strobe,
  output g2_af_t o_load_q,
  output key_t   o_load_key,
  output logic   o_busy
);

  g2_af_t    q_shift;   // New words enter at the top and move down
  key_t      key_q;
  word_cnt_t word_cnt;
  logic      load_strobe;
  logic      busy;

  logic take_word;
  logic last_word;

  assign take_word = i_in_strobe && !busy;
  assign last_word = (word_cnt == word_cnt_t'(`IN_WORDS - 1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      q_shift     <= '0;
      key_q       <= '0;
      word_cnt    <= '0;
      load_strobe <= 1'b0;
      busy        <= 1'b0;
    end else begin
      load_strobe <= 1'b0;
      if (i_done_strobe) begin
        busy <= 1'b0;
      end
      if (take_word) begin
        q_shift <= g2_af_t'({i_in_word, q_shift[$bits(g2_af_t)-1:`FE_BITS]});
        if (word_cnt == '0) begin
          key_q <= i_key;  // Key rides with the first word
        end
        if (last_word) begin
          word_cnt    <= '0;
          load_strobe <= 1'b1;
          busy        <= 1'b1;
        end else begin
          word_cnt <= word_cnt + 1'b1;
        end
      end
    end
  end

  assign o_load_strobe = load_strobe;
  assign o_load_q      = q_shift;  // Held stable while busy
  assign o_load_key    = key_q;
  assign o_busy        = busy;

endmodule

`default_nettype wire

//--- design/g2_result_serializer.sv
// Sends a Jacobian point as six consecutive words, x.c0 first and z.c1 last.
// Output starts the cycle after i_done_strobe; there is no back-pressure.
// A new i_done_strobe during output restarts the frame.
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module g2_result_serializer
  import g2_smul_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_done_strobe,
  input  g2_jb_t i_result,
  output logic   o_out_strobe,
  output fe_t    o_out_word,
  output logic   o_out_first,
  output logic   o_out_last
);

  g2_jb_t    shift_q;  // Current word in the low bits
  word_cnt_t cnt;      // Index of the word now on the output, 1 based
  logic      out_strobe;
  logic      out_first;
  logic      out_last;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      shift_q    <= '0;
      cnt        <= '0;
      out_strobe <= 1'b0;
      out_first  <= 1'b0;
      out_last   <= 1'b0;
    end else if (i_done_strobe) begin
      shift_q    <= i_result;
      cnt        <= word_cnt_t'(1);
      out_strobe <= 1'b1;
      out_first  <= 1'b1;
      out_last   <= 1'b0;
    end else if (out_strobe) begin
      shift_q   <= g2_jb_t'(shift_q >> `FE_BITS);  // Empties to zero after word six
      out_first <= 1'b0;
      if (cnt == word_cnt_t'(`OUT_WORDS)) begin
        cnt        <= '0;
        out_strobe <= 1'b0;
        out_last   <= 1'b0;
      end else begin
        cnt      <= cnt + 1'b1;
        out_last <= (cnt == word_cnt_t'(`OUT_WORDS - 1));
      end
    end
  end

  assign o_out_strobe = out_strobe;
  assign o_out_word   = shift_q[`FE_BITS-1:0];
  assign o_out_first  = out_first;
  assign o_out_last   = out_last;

endmodule

`default_nettype wire

//--- design/g2_smul_config.svh
// Build-time sizes for the G2 scalar-multiply path.
// FE_BITS is fixed by BLS12-381; KEY_BITS may be changed, the key is scanned MSB first.
// Word counts describe the serial framing on the input and output ports.
`ifndef G2_SMUL_CONFIG_SVH
`define G2_SMUL_CONFIG_SVH

// One Fp element
`define FE_BITS 381

// Scalar width, kept short for simulation
`define KEY_BITS 64

`define IN_WORDS 4   // Affine Q: x.c0, x.c1, y.c0, y.c1
`define OUT_WORDS 6  // Jacobian R: x, y, z pairs

`endif

//--- design/g2_smul_pkg.sv
// Types shared by the G2 scalar-multiply RTL and its testbench.
// Struct fields are listed MSB first, so c0 and x sit in the low bits.
// Serial words therefore go out of and into the low end of each point.
`default_nettype none

`include "g2_smul_config.svh"

package g2_smul_pkg;

  // One Fp word, not reduced by this design
  typedef logic [`FE_BITS-1:0] fe_t;

  typedef struct packed {
    fe_t c1;
    fe_t c0;  // Low word, sent first
  } fe2_t;

  // Affine G2 point
  typedef struct packed {
    fe2_t y;
    fe2_t x;
  } g2_af_t;

  // Jacobian G2 point, infinity is all zero
  typedef struct packed {
    fe2_t z;
    fe2_t y;
    fe2_t x;
  } g2_jb_t;

  typedef logic [`KEY_BITS-1:0] key_t;

  typedef logic [$clog2(`OUT_WORDS+1)-1:0] word_cnt_t;  // Also covers IN_WORDS

  typedef enum logic {
    OP_DBL = 1'b0,  // r <- 2r
    OP_ADD = 1'b1   // r <- r + q
  } point_op_e;

  typedef struct packed {
    point_op_e op;
    g2_jb_t    r;
    g2_af_t    q;
  } point_req_t;

endpackage

`default_nettype wire

//--- design/g2_smul_sequencer.sv
// Left-to-right double-and-add over the key, MSB first.
// Leading zeros cost one cycle each; the first one loads R = (Qx, Qy, 1).
// Point arithmetic is external, one request in flight, one response per request.
// A zero key finishes with the all-zero point (infinity).
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module g2_smul_sequencer
  import g2_smul_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_load_strobe,
  input  g2_af_t     i_load_q,
  input  key_t       i_load_key,
  output logic       o_op_strobe,
  output point_req_t o_op_req,
  input  logic       i_res_strobe,
  input  g2_jb_t     i_res_point,
  output logic       o_done_strobe,
  output g2_jb_t     o_result
);

  typedef logic [$clog2(`KEY_BITS+1)-1:0] bit_cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    SCAN,
    DBL,
    ADD,
    DONE
  } state_e;

  state_e     state;
  key_t       key_sr;    // Current bit at the MSB
  bit_cnt_t   bit_cnt;   // Bits not yet consumed, current one included
  logic       waiting;   // A request is outstanding
  logic       op_strobe;
  point_req_t op_req;
  g2_af_t     q_reg;
  g2_jb_t     acc;       // Running R

  logic      key_msb;
  logic      last_bit;
  logic      issue;
  point_op_e issue_op;
  g2_jb_t    issue_r;

  assign key_msb  = key_sr[`KEY_BITS-1];
  assign last_bit = (bit_cnt == bit_cnt_t'(1));

  // Next request is decided here so it can follow a response on the very next cycle
  always_comb begin
    issue    = 1'b0;
    issue_op = OP_DBL;
    issue_r  = i_res_point;
    case (state)
      DBL: begin
        if (!waiting) begin
          issue   = 1'b1;   // First doubling after the leading one
          issue_r = acc;
        end else if (i_res_strobe) begin
          if (key_msb) begin
            issue    = 1'b1;
            issue_op = OP_ADD;
          end else if (!last_bit) begin
            issue = 1'b1;
          end
        end
      end
      ADD: begin
        if (i_res_strobe && !last_bit) begin
          issue = 1'b1;
        end
      end
      default: begin
        issue = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= IDLE;
      key_sr    <= '0;
      bit_cnt   <= '0;
      waiting   <= 1'b0;
      op_strobe <= 1'b0;
    end else begin
      op_strobe <= issue;
      waiting   <= issue || (waiting && !i_res_strobe);
      case (state)
        IDLE: begin
          if (i_load_strobe) begin
            key_sr  <= i_load_key;
            bit_cnt <= bit_cnt_t'(`KEY_BITS);
            state   <= SCAN;
          end
        end
        SCAN: begin
          key_sr  <= key_sr << 1;
          bit_cnt <= bit_cnt - 1'b1;
          if (last_bit) begin
            state <= DONE;
          end else if (key_msb) begin
            state <= DBL;
          end
        end
        DBL: begin
          if (waiting && i_res_strobe) begin
            if (key_msb) begin
              state <= ADD;     // Bit is one, add before moving on
            end else begin
              key_sr  <= key_sr << 1;
              bit_cnt <= bit_cnt - 1'b1;
              if (last_bit) begin
                state <= DONE;
              end
            end
          end
        end
        ADD: begin
          if (i_res_strobe) begin
            key_sr  <= key_sr << 1;
            bit_cnt <= bit_cnt - 1'b1;
            state   <= last_bit ? DONE : DBL;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_load_strobe) begin
      q_reg <= i_load_q;
      acc   <= '0;  // Stays infinity for a zero key
    end else if (state == SCAN && key_msb) begin
      acc.x    <= q_reg.x;
      acc.y    <= q_reg.y;
      acc.z.c0 <= fe_t'(1);
      acc.z.c1 <= '0;
    end else if (waiting && i_res_strobe) begin
      acc <= i_res_point;
    end
    if (issue) begin
      op_req <= '{op: issue_op, r: issue_r, q: q_reg};
    end
  end

  assign o_op_strobe   = op_strobe;
  assign o_op_req      = op_req;
  assign o_done_strobe = (state == DONE);  // One cycle after the final response
  assign o_result      = acc;

endmodule

`default_nettype wire

//--- design/g2_smul_top.sv
// Scalar multiply key*Q on G2 with an external point-arithmetic unit.
// Input: four affine words with the key on the first; output: six Jacobian words.
// o_busy covers the whole job up to and including the last output word.
// Strobes only, no back-pressure on any port.
`timescale 1ns/1ps
`default_nettype none

`include "g2_smul_config.svh"

module g2_smul_top
  import g2_smul_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  // Serial affine Q and key
  input  logic       i_in_strobe,
  input  fe_t        i_in_word,
  input  key_t       i_key,
  output logic       o_busy,
  // Point arithmetic unit
  output logic       o_op_strobe,
  output point_req_t o_op_req,
  input  logic       i_res_strobe,
  input  g2_jb_t     i_res_point,
  // Serial Jacobian result
  output logic       o_out_strobe,
  output fe_t        o_out_word,
  output logic       o_out_first,
  output logic       o_out_last
);

  logic   load_strobe;
  g2_af_t load_q;
  key_t   load_key;
  logic   done_strobe;
  g2_jb_t result;

  // Busy is released by the last output word, not by the sequencer finishing
  g2_input_loader g2_input_loader_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_in_strobe   (i_in_strobe),
    .i_in_word     (i_in_word),
    .i_key         (i_key),
    .i_done_strobe (o_out_last),
    .o_load_strobe (load_strobe),
    .o_load_q      (load_q),
    .o_load_key    (load_key),
    .o_busy        (o_busy)
  );

  g2_smul_sequencer g2_smul_sequencer_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_load_strobe (load_strobe),
    .i_load_q      (load_q),
    .i_load_key    (load_key),
    .o_op_strobe   (o_op_strobe),
    .o_op_req      (o_op_req),
    .i_res_strobe  (i_res_strobe),
    .i_res_point   (i_res_point),
    .o_done_strobe (done_strobe),
    .o_result      (result)
  );

  g2_result_serializer g2_result_serializer_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_done_strobe (done_strobe),
    .i_result      (result),
    .o_out_strobe  (o_out_strobe),
    .o_out_word    (o_out_word),
    .o_out_first   (o_out_first),
    .o_out_last    (o_out_last)
  );

endmodule

`default_nettype wire
